// ==== logic/wasm_ctrl_pkg.sv ====
// widths, opcodes, ALU/push/immediate/state enums and the stack control word
`default_nettype none

package wasm_ctrl_pkg;

    localparam int WINDOW_BYTES = 8; // bytes offered by instruction memory

    typedef logic [8*WINDOW_BYTES-1:0] window_t; // byte 0 in [7:0]
    typedef logic [7:0]                advance_t;
    typedef logic [31:0]               word_t;
    typedef logic [2:0]                leb_len_t; // 1..5

    localparam window_t WASM_HEADER = 64'h0000_0001_6d73_6100; // "\0asm" + version 1, LE
    localparam logic [7:0] SEC_CODE = 8'h0a;

    localparam logic [7:0] OP_UNREACHABLE = 8'h00;
    localparam logic [7:0] OP_NOP         = 8'h01;
    localparam logic [7:0] OP_END         = 8'h0b;
    localparam logic [7:0] OP_DROP        = 8'h1a;
    localparam logic [7:0] OP_SELECT      = 8'h1b;
    localparam logic [7:0] OP_LOCAL_GET   = 8'h20;
    localparam logic [7:0] OP_LOCAL_SET   = 8'h21;
    localparam logic [7:0] OP_LOCAL_TEE   = 8'h22;
    localparam logic [7:0] OP_I32_LOAD    = 8'h28;
    localparam logic [7:0] OP_I32_STORE   = 8'h36;
    localparam logic [7:0] OP_I32_CONST   = 8'h41;
    localparam logic [7:0] OP_I32_EQZ     = 8'h45;
    localparam logic [7:0] OP_I32_EQ      = 8'h46;
    localparam logic [7:0] OP_I32_NE      = 8'h47;
    localparam logic [7:0] OP_I32_LT_S    = 8'h48;
    localparam logic [7:0] OP_I32_LT_U    = 8'h49;
    localparam logic [7:0] OP_I32_GT_S    = 8'h4a;
    localparam logic [7:0] OP_I32_GT_U    = 8'h4b;
    localparam logic [7:0] OP_I32_LE_S    = 8'h4c;
    localparam logic [7:0] OP_I32_LE_U    = 8'h4d;
    localparam logic [7:0] OP_I32_GE_S    = 8'h4e;
    localparam logic [7:0] OP_I32_GE_U    = 8'h4f;
    localparam logic [7:0] OP_I32_ADD     = 8'h6a;
    localparam logic [7:0] OP_I32_SUB     = 8'h6b;
    localparam logic [7:0] OP_I32_AND     = 8'h71;
    localparam logic [7:0] OP_I32_OR      = 8'h72;
    localparam logic [7:0] OP_I32_SHL     = 8'h74;
    localparam logic [7:0] OP_I32_SHR_S   = 8'h75;
    localparam logic [7:0] OP_I32_SHR_U   = 8'h76;
    localparam logic [7:0] OP_I32_ROTL    = 8'h77;
    localparam logic [7:0] OP_I32_ROTR    = 8'h78;

    typedef enum logic [4:0] {
        ALU_ADD   = 5'd0,  ALU_SUB  = 5'd1,  ALU_AND  = 5'd2,  ALU_OR   = 5'd3,
        ALU_SEL   = 5'd4,  ALU_EQZ  = 5'd5,  ALU_EQ   = 5'd6,
        ALU_LT_U  = 5'd7,  ALU_GT_U = 5'd8,  ALU_LE_U = 5'd9,  ALU_GE_U = 5'd10,
        ALU_LT_S  = 5'd11, ALU_GT_S = 5'd12, ALU_LE_S = 5'd13, ALU_GE_S = 5'd14,
        ALU_NE    = 5'd15,
        ALU_SHL   = 5'd16, ALU_SHR_S = 5'd17, ALU_SHR_U = 5'd18,
        ALU_ROTL  = 5'd19, ALU_ROTR  = 5'd20
    } alu_op_t;

    typedef enum logic [1:0] {
        PUSH_ALU   = 2'd0,
        PUSH_MEM   = 2'd1,
        PUSH_IMM   = 2'd2,
        PUSH_LOCAL = 2'd3
    } push_src_t;

    typedef enum logic [1:0] {
        IMM_NONE   = 2'd0,
        IMM_LEB    = 2'd1,
        IMM_MEMARG = 2'd2 // align byte, then offset LEB128
    } imm_kind_t;

    typedef enum logic [2:0] {
        MOD_HEAD, SEC_HEAD, SKIP_SEC, CODE_COUNT, BODY_HEAD, BODY_OPS, HALT
    } parse_state_t;

    typedef struct packed {
        logic [1:0] pop_cnt;
        logic       push;
        push_src_t  push_src;
        alu_op_t    alu_op;
        logic       load;
        logic       store;
        logic       local_get;
        logic       local_set;
    } stack_ctrl_t;

endpackage

`default_nettype wire

// ==== logic/leb128_decoder.sv ====
// unsigned LEB128 decoder, up to five bytes, purely combinational
`default_nettype none

module leb128_decoder (
    input  wire  [39:0]                bytes,
    output wasm_ctrl_pkg::word_t    value,
    output wasm_ctrl_pkg::leb_len_t len
);

    logic found; // terminating byte already seen

    always_comb begin
        value = '0;
        len   = wasm_ctrl_pkg::leb_len_t'(5); // all five continue
        found = 1'b0;
        for (int i = 0; i < 5; i++) begin
            if (!found) begin
                // top bits of the fifth group fall off the 32-bit result
                value = value | (wasm_ctrl_pkg::word_t'(bytes[8*i +: 7]) << (7*i));
                if (!bytes[8*i+7]) begin
                    len   = wasm_ctrl_pkg::leb_len_t'(i + 1);
                    found = 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/opcode_decoder.sv ====
// opcode byte to stack/ALU control word, immediate kind and executable flag
`default_nettype none

module opcode_decoder (
    input  wire  [7:0]                  opcode,
    output wasm_ctrl_pkg::stack_ctrl_t ctrl,
    output wasm_ctrl_pkg::imm_kind_t   imm_kind,
    output logic                        executable
);

    // common shape of ops whose result comes back from the ALU
    function automatic wasm_ctrl_pkg::stack_ctrl_t alu_ctrl(
        input logic [1:0]             pops,
        input wasm_ctrl_pkg::alu_op_t op
    );
        wasm_ctrl_pkg::stack_ctrl_t c;
        c          = '0;
        c.pop_cnt  = pops;
        c.push     = 1'b1;
        c.push_src = wasm_ctrl_pkg::PUSH_ALU;
        c.alu_op   = op;
        return c;
    endfunction

    always_comb begin
        ctrl       = '0; // no pop, no push, add
        imm_kind   = wasm_ctrl_pkg::IMM_NONE;
        executable = 1'b1;
        case (opcode)
            wasm_ctrl_pkg::OP_UNREACHABLE,
            wasm_ctrl_pkg::OP_NOP,
            wasm_ctrl_pkg::OP_END: begin
                executable = 1'b0; // handled by the parser
            end
            wasm_ctrl_pkg::OP_DROP: begin
                ctrl.pop_cnt = 2'd1;
            end
            wasm_ctrl_pkg::OP_SELECT: ctrl = alu_ctrl(2'd3, wasm_ctrl_pkg::ALU_SEL);
            wasm_ctrl_pkg::OP_I32_CONST: begin
                ctrl.push     = 1'b1;
                ctrl.push_src = wasm_ctrl_pkg::PUSH_IMM;
                imm_kind      = wasm_ctrl_pkg::IMM_LEB;
            end
            wasm_ctrl_pkg::OP_LOCAL_GET: begin
                ctrl.push      = 1'b1;
                ctrl.push_src  = wasm_ctrl_pkg::PUSH_LOCAL;
                ctrl.local_get = 1'b1;
                imm_kind       = wasm_ctrl_pkg::IMM_LEB; // local index
            end
            wasm_ctrl_pkg::OP_LOCAL_SET: begin
                ctrl.pop_cnt   = 2'd1;
                ctrl.local_set = 1'b1;
                imm_kind       = wasm_ctrl_pkg::IMM_LEB;
            end
            wasm_ctrl_pkg::OP_LOCAL_TEE: begin
                ctrl.local_set = 1'b1; // value stays on the stack
                imm_kind       = wasm_ctrl_pkg::IMM_LEB;
            end
            wasm_ctrl_pkg::OP_I32_LOAD: begin
                ctrl.pop_cnt  = 2'd1; // address
                ctrl.push     = 1'b1;
                ctrl.push_src = wasm_ctrl_pkg::PUSH_MEM;
                ctrl.load     = 1'b1;
                imm_kind      = wasm_ctrl_pkg::IMM_MEMARG;
            end
            wasm_ctrl_pkg::OP_I32_STORE: begin
                ctrl.pop_cnt = 2'd2; // address and value
                ctrl.store   = 1'b1;
                imm_kind     = wasm_ctrl_pkg::IMM_MEMARG;
            end
            wasm_ctrl_pkg::OP_I32_EQZ:   ctrl = alu_ctrl(2'd1, wasm_ctrl_pkg::ALU_EQZ);
            wasm_ctrl_pkg::OP_I32_EQ:    ctrl = alu_ctrl(2'd2, wasm_ctrl_pkg::ALU_EQ);
            wasm_ctrl_pkg::OP_I32_NE:    ctrl = alu_ctrl(2'd2, wasm_ctrl_pkg::ALU_NE);
            wasm_ctrl_pkg::OP_I32_LT_S:  ctrl = alu_ctrl(2'd2, wasm_ctrl_pkg::ALU_LT_S);
            wasm_ctrl_pkg::OP_I32_LT_U:  ctrl = alu_ctrl(2'd2, wasm_ctrl_pkg::ALU_LT_U);
            wasm_ctrl_pkg::OP_I32_GT_S:  ctrl = alu_ctrl(2'd2, wasm_ctrl_pkg::ALU_GT_S);
            wasm_ctrl_pkg::OP_I32_GT_U:  ctrl = alu_ctrl(2'd2, wasm_ctrl_pkg::ALU_GT_U);
            wasm_ctrl_pkg::OP_I32_LE_S:  ctrl = alu_ctrl(2'd2, wasm_ctrl_pkg::ALU_LE_S);
            wasm_ctrl_pkg::OP_I32_LE_U:  ctrl = alu_ctrl(2'd2, wasm_ctrl_pkg::ALU_LE_U);
            wasm_ctrl_pkg::OP_I32_GE_S:  ctrl = alu_ctrl(2'd2, wasm_ctrl_pkg::ALU_GE_S);
            wasm_ctrl_pkg::OP_I32_GE_U:  ctrl = alu_ctrl(2'd2, wasm_ctrl_pkg::ALU_GE_U);
            wasm_ctrl_pkg::OP_I32_ADD:   ctrl = alu_ctrl(2'd2, wasm_ctrl_pkg::ALU_ADD);
            wasm_ctrl_pkg::OP_I32_SUB:   ctrl = alu_ctrl(2'd2, wasm_ctrl_pkg::ALU_SUB);
            wasm_ctrl_pkg::OP_I32_AND:   ctrl = alu_ctrl(2'd2, wasm_ctrl_pkg::ALU_AND);
            wasm_ctrl_pkg::OP_I32_OR:    ctrl = alu_ctrl(2'd2, wasm_ctrl_pkg::ALU_OR);
            wasm_ctrl_pkg::OP_I32_SHL:   ctrl = alu_ctrl(2'd2, wasm_ctrl_pkg::ALU_SHL);
            wasm_ctrl_pkg::OP_I32_SHR_S: ctrl = alu_ctrl(2'd2, wasm_ctrl_pkg::ALU_SHR_S);
            wasm_ctrl_pkg::OP_I32_SHR_U: ctrl = alu_ctrl(2'd2, wasm_ctrl_pkg::ALU_SHR_U);
            wasm_ctrl_pkg::OP_I32_ROTL:  ctrl = alu_ctrl(2'd2, wasm_ctrl_pkg::ALU_ROTL);
            wasm_ctrl_pkg::OP_I32_ROTR:  ctrl = alu_ctrl(2'd2, wasm_ctrl_pkg::ALU_ROTR);
            default: begin
                executable = 1'b0; // unknown, skipped like nop
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/section_parser.sv ====
// module header, section and code body FSM driving the window advance
`default_nettype none

module section_parser (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           window_vld,
    input  wasm_ctrl_pkg::window_t     window,
    input  wasm_ctrl_pkg::imm_kind_t   imm_kind,
    output wasm_ctrl_pkg::advance_t    advance,
    output logic                          in_body,
    output wasm_ctrl_pkg::word_t       imm,
    output logic                          error,
    output logic                          done
);

    wasm_ctrl_pkg::parse_state_t state;
    wasm_ctrl_pkg::parse_state_t state_nxt;
    wasm_ctrl_pkg::advance_t     sec_len;
    wasm_ctrl_pkg::word_t        body_left;
    wasm_ctrl_pkg::word_t        body_left_nxt;
    logic                        err_set;
    logic                        done_set;

    logic [39:0]                 leb_a_in;
    wasm_ctrl_pkg::word_t        val_a;
    wasm_ctrl_pkg::word_t        val_b;
    wasm_ctrl_pkg::leb_len_t     len_a;
    wasm_ctrl_pkg::leb_len_t     len_b;
    logic [7:0]                  opcode;
    logic [7:0]                  local_cnt;

    // count and body size start at byte 0, everything else after an id/opcode byte
    assign leb_a_in = (state == wasm_ctrl_pkg::CODE_COUNT || state == wasm_ctrl_pkg::BODY_HEAD)
                    ? window[39:0] : window[47:8];

    leb128_decoder i_leb_a (
        .bytes (leb_a_in),
        .value (val_a),
        .len   (len_a)
    );

    leb128_decoder i_leb_b ( // memarg offset after the align byte
        .bytes (window[55:16]),
        .value (val_b),
        .len   (len_b)
    );

    assign opcode    = window[7:0];
    assign local_cnt = window[8*len_a +: 8]; // byte right after the body size
    assign in_body   = (state == wasm_ctrl_pkg::BODY_OPS);
    assign imm       = (imm_kind == wasm_ctrl_pkg::IMM_MEMARG) ? val_b : val_a;

    always_comb begin
        state_nxt     = state;
        advance       = '0;
        err_set       = 1'b0;
        done_set      = 1'b0;
        body_left_nxt = body_left;
        case (state)
            wasm_ctrl_pkg::MOD_HEAD: begin
                if (window == wasm_ctrl_pkg::WASM_HEADER) begin
                    advance   = wasm_ctrl_pkg::advance_t'(wasm_ctrl_pkg::WINDOW_BYTES);
                    state_nxt = wasm_ctrl_pkg::SEC_HEAD;
                end else begin
                    err_set   = 1'b1;
                    state_nxt = wasm_ctrl_pkg::HALT;
                end
            end
            wasm_ctrl_pkg::SEC_HEAD: begin
                advance = wasm_ctrl_pkg::advance_t'(len_a) + 8'd1;
                if (opcode == wasm_ctrl_pkg::SEC_CODE) begin
                    state_nxt = wasm_ctrl_pkg::CODE_COUNT;
                end else if (val_a > 32'd255) begin // too long to skip in one step
                    err_set   = 1'b1;
                    state_nxt = wasm_ctrl_pkg::HALT;
                end else begin
                    state_nxt = wasm_ctrl_pkg::SKIP_SEC;
                end
            end
            wasm_ctrl_pkg::SKIP_SEC: begin
                advance   = sec_len;
                state_nxt = wasm_ctrl_pkg::SEC_HEAD;
            end
            wasm_ctrl_pkg::CODE_COUNT: begin
                advance       = wasm_ctrl_pkg::advance_t'(len_a);
                body_left_nxt = val_a;
                if (val_a == '0) begin // empty code section
                    done_set  = 1'b1;
                    state_nxt = wasm_ctrl_pkg::HALT;
                end else begin
                    state_nxt = wasm_ctrl_pkg::BODY_HEAD;
                end
            end
            wasm_ctrl_pkg::BODY_HEAD: begin
                advance = wasm_ctrl_pkg::advance_t'(len_a) + 8'd1;
                if (local_cnt != 8'd0) begin // local declarations not supported
                    err_set   = 1'b1;
                    state_nxt = wasm_ctrl_pkg::HALT;
                end else begin
                    state_nxt = wasm_ctrl_pkg::BODY_OPS;
                end
            end
            wasm_ctrl_pkg::BODY_OPS: begin
                case (imm_kind)
                    wasm_ctrl_pkg::IMM_LEB:
                        advance = wasm_ctrl_pkg::advance_t'(len_a) + 8'd1;
                    wasm_ctrl_pkg::IMM_MEMARG:
                        advance = wasm_ctrl_pkg::advance_t'(len_b) + 8'd2;
                    default:
                        advance = 8'd1;
                endcase
                if (opcode == wasm_ctrl_pkg::OP_UNREACHABLE) begin
                    err_set   = 1'b1;
                    state_nxt = wasm_ctrl_pkg::HALT;
                end else if (opcode == wasm_ctrl_pkg::OP_END) begin
                    if (body_left == 32'd1) begin
                        done_set  = 1'b1;
                        state_nxt = wasm_ctrl_pkg::HALT;
                    end else begin
                        body_left_nxt = body_left - 32'd1;
                        state_nxt     = wasm_ctrl_pkg::BODY_HEAD;
                    end
                end
            end
            default: begin
                state_nxt = wasm_ctrl_pkg::HALT; // parked, advance stays 0
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= wasm_ctrl_pkg::MOD_HEAD;
            body_left <= '0;
            error     <= 1'b0;
            done      <= 1'b0;
        end else if (window_vld) begin
            state     <= state_nxt;
            body_left <= body_left_nxt;
            error     <= error | err_set; // sticky
            done      <= done | done_set;
        end
    end

    always_ff @(posedge clk) begin
        if (window_vld && state == wasm_ctrl_pkg::SEC_HEAD) begin
            sec_len <= val_a[7:0];
        end
    end

endmodule

`default_nettype wire

// ==== logic/wasm_ctrl_unit.sv ====
// WebAssembly control unit top, section parser plus opcode decoder
`default_nettype none

module wasm_ctrl_unit (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           window_vld,
    input  wasm_ctrl_pkg::window_t     window,
    output wasm_ctrl_pkg::advance_t    advance,
    output wasm_ctrl_pkg::stack_ctrl_t ctrl,
    output wasm_ctrl_pkg::word_t       imm,
    output logic                          op_vld,
    output logic                          error,
    output logic                          done
);

    wasm_ctrl_pkg::imm_kind_t imm_kind;
    logic                     in_body;
    logic                     executable;

    section_parser i_section_parser (
        .clk        (clk),
        .rst_n      (rst_n),
        .window_vld (window_vld),
        .window     (window),
        .imm_kind   (imm_kind),
        .advance    (advance),
        .in_body    (in_body),
        .imm        (imm),
        .error      (error),
        .done       (done)
    );

    opcode_decoder i_opcode_decoder (
        .opcode     (window[7:0]), // byte at the read position
        .ctrl       (ctrl),
        .imm_kind   (imm_kind),
        .executable (executable)
    );

    assign op_vld = window_vld & in_body & executable;

endmodule

`default_nettype wire

// ==== verif/wasm_ctrl_unit_chk.sv ====
// concurrent assertions on the control unit handshake and its sticky flags
`default_nettype none

module wasm_ctrl_unit_chk (
    input wire       clk,
    input wire       rst_n,
    input wire       window_vld,
    input wire [7:0] advance,
    input wire       op_vld,
    input wire       error,
    input wire       done
);

    op_needs_window: assert property (
        @(posedge clk) disable iff (!rst_n) op_vld |-> window_vld
    ) else $error("op_vld high while window_vld is low");

    halted_no_advance: assert property (
        @(posedge clk) disable iff (!rst_n) (error || done) |-> advance == 8'd0
    ) else $error("advance nonzero after error or done");

    error_sticky: assert property (
        @(posedge clk) disable iff (!rst_n) error |=> error
    ) else $error("error fell without reset");

    done_sticky: assert property (
        @(posedge clk) disable iff (!rst_n) done |=> done
    ) else $error("done fell without reset");

endmodule

bind wasm_ctrl_unit wasm_ctrl_unit_chk i_wasm_ctrl_unit_chk (
    .clk        (clk),
    .rst_n      (rst_n),
    .window_vld (window_vld),
    .advance    (advance),
    .op_vld     (op_vld),
    .error      (error),
    .done       (done)
);

`default_nettype wire

// ==== verif/wasm_ctrl_unit_tb.sv ====
// testbench for the control unit with module builder, memory model, op table, checks and watchdog
`default_nettype none

module wasm_ctrl_unit_tb;

    typedef wasm_ctrl_pkg::stack_ctrl_t ctrl_t;
    typedef wasm_ctrl_pkg::word_t       word_t;

    typedef struct packed {
        logic [7:0]               op;
        wasm_ctrl_pkg::imm_kind_t kind;
        logic [2:0]               leb_len; // bytes of the immediate or offset
        word_t                    imm;
        logic [7:0]               align;
        ctrl_t                    exp;
    } row_t;

    localparam logic [63:0] MAGIC_VERSION = 64'h0061736d_01000000; // stream order

    logic                    clk;
    logic                    rst_n;
    logic                    window_vld;
    wasm_ctrl_pkg::window_t  window;
    wasm_ctrl_pkg::advance_t advance;
    ctrl_t                   ctrl;
    word_t                   imm;
    logic                    op_vld;
    logic                    error;
    logic                    done;

    row_t       table_q[$];
    row_t       exp_q[$];
    logic [7:0] prog[$];
    logic [7:0] code[$];
    logic [7:0] body[$];
    int         value_errors;
    int         flow_errors;
    int         run_limit;
    logic       run_active;

    wasm_ctrl_unit i_wasm_ctrl_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .window_vld (window_vld),
        .window     (window),
        .advance    (advance),
        .ctrl       (ctrl),
        .imm        (imm),
        .op_vld     (op_vld),
        .error      (error),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles <= run_limit) begin
            @(posedge clk);
            cycles = run_active ? cycles + 1 : 0;
        end
        $display("timeout: a run went past %0d cycles without ending", run_limit);
        $display("Something failed");
        $finish;
    end

    function automatic int leb_size(input word_t v);
        int n;
        n = 1;
        while (n < 5 && (v >> (7*n)) != 0) n++;
        return n;
    endfunction

    // byte i of an n-byte unsigned LEB128 encoding
    function automatic logic [7:0] leb_byte(input word_t v, input int n, input int i);
        logic [7:0] b;
        b = 8'((v >> (7*i)) & 32'h7f);
        if (i < n - 1) b = b | 8'h80;
        return b;
    endfunction

    function automatic ctrl_t expect_ctrl(input int pops, input logic push,
                                          input wasm_ctrl_pkg::push_src_t src,
                                          input wasm_ctrl_pkg::alu_op_t alu,
                                          input logic [3:0] strobes); // load store get set
        ctrl_t c;
        c.pop_cnt  = 2'(pops);
        c.push     = push;
        c.push_src = src;
        c.alu_op   = alu;
        {c.load, c.store, c.local_get, c.local_set} = strobes;
        return c;
    endfunction

    function automatic wasm_ctrl_pkg::window_t fetch(input int p);
        wasm_ctrl_pkg::window_t w;
        w = '0;
        for (int i = 0; i < 8; i++) begin
            if (p + i < prog.size()) w[8*i +: 8] = prog[p + i]; // zeros past the end
        end
        return w;
    endfunction

    task automatic add_row(input logic [7:0] op, input wasm_ctrl_pkg::imm_kind_t kind,
                           input int n, input ctrl_t exp);
        row_t  r;
        word_t mask;
        mask      = (n >= 5) ? '1 : ((32'd1 << (7*n)) - 32'd1);
        r.op      = op;
        r.kind    = kind;
        r.leb_len = 3'(n);
        r.imm     = $urandom & mask;
        r.align   = 8'($urandom % 3);
        r.exp     = exp;
        table_q.push_back(r);
    endtask

    task automatic add_alu_row(input logic [7:0] op, input int pops,
                               input wasm_ctrl_pkg::alu_op_t alu);
        add_row(op, wasm_ctrl_pkg::IMM_NONE, 0,
                expect_ctrl(pops, 1'b1, wasm_ctrl_pkg::PUSH_ALU, alu, 4'b0000));
    endtask

    task automatic fill_table();
        for (int n = 1; n <= 5; n++) begin
            add_row(wasm_ctrl_pkg::OP_I32_CONST, wasm_ctrl_pkg::IMM_LEB, n,
                    expect_ctrl(0, 1'b1, wasm_ctrl_pkg::PUSH_IMM, wasm_ctrl_pkg::ALU_ADD, 4'b0000));
        end
        add_row(wasm_ctrl_pkg::OP_LOCAL_GET, wasm_ctrl_pkg::IMM_LEB, 1,
                expect_ctrl(0, 1'b1, wasm_ctrl_pkg::PUSH_LOCAL, wasm_ctrl_pkg::ALU_ADD, 4'b0010));
        add_row(wasm_ctrl_pkg::OP_LOCAL_SET, wasm_ctrl_pkg::IMM_LEB, 2,
                expect_ctrl(1, 1'b0, wasm_ctrl_pkg::PUSH_ALU, wasm_ctrl_pkg::ALU_ADD, 4'b0001));
        add_row(wasm_ctrl_pkg::OP_LOCAL_TEE, wasm_ctrl_pkg::IMM_LEB, 1,
                expect_ctrl(0, 1'b0, wasm_ctrl_pkg::PUSH_ALU, wasm_ctrl_pkg::ALU_ADD, 4'b0001));
        add_row(wasm_ctrl_pkg::OP_I32_LOAD, wasm_ctrl_pkg::IMM_MEMARG, 1,
                expect_ctrl(1, 1'b1, wasm_ctrl_pkg::PUSH_MEM, wasm_ctrl_pkg::ALU_ADD, 4'b1000));
        add_row(wasm_ctrl_pkg::OP_I32_STORE, wasm_ctrl_pkg::IMM_MEMARG, 3,
                expect_ctrl(2, 1'b0, wasm_ctrl_pkg::PUSH_ALU, wasm_ctrl_pkg::ALU_ADD, 4'b0100));
        add_row(wasm_ctrl_pkg::OP_DROP, wasm_ctrl_pkg::IMM_NONE, 0,
                expect_ctrl(1, 1'b0, wasm_ctrl_pkg::PUSH_ALU, wasm_ctrl_pkg::ALU_ADD, 4'b0000));
        add_alu_row(wasm_ctrl_pkg::OP_SELECT, 3, wasm_ctrl_pkg::ALU_SEL);
        add_alu_row(wasm_ctrl_pkg::OP_I32_EQZ, 1, wasm_ctrl_pkg::ALU_EQZ);
        add_alu_row(wasm_ctrl_pkg::OP_I32_EQ, 2, wasm_ctrl_pkg::ALU_EQ);
        add_alu_row(wasm_ctrl_pkg::OP_I32_NE, 2, wasm_ctrl_pkg::ALU_NE);
        add_alu_row(wasm_ctrl_pkg::OP_I32_LT_S, 2, wasm_ctrl_pkg::ALU_LT_S);
        add_alu_row(wasm_ctrl_pkg::OP_I32_LT_U, 2, wasm_ctrl_pkg::ALU_LT_U);
        add_alu_row(wasm_ctrl_pkg::OP_I32_GT_S, 2, wasm_ctrl_pkg::ALU_GT_S);
        add_alu_row(wasm_ctrl_pkg::OP_I32_GT_U, 2, wasm_ctrl_pkg::ALU_GT_U);
        add_alu_row(wasm_ctrl_pkg::OP_I32_LE_S, 2, wasm_ctrl_pkg::ALU_LE_S);
        add_alu_row(wasm_ctrl_pkg::OP_I32_LE_U, 2, wasm_ctrl_pkg::ALU_LE_U);
        add_alu_row(wasm_ctrl_pkg::OP_I32_GE_S, 2, wasm_ctrl_pkg::ALU_GE_S);
        add_alu_row(wasm_ctrl_pkg::OP_I32_GE_U, 2, wasm_ctrl_pkg::ALU_GE_U);
        add_alu_row(wasm_ctrl_pkg::OP_I32_ADD, 2, wasm_ctrl_pkg::ALU_ADD);
        add_alu_row(wasm_ctrl_pkg::OP_I32_SUB, 2, wasm_ctrl_pkg::ALU_SUB);
        add_alu_row(wasm_ctrl_pkg::OP_I32_AND, 2, wasm_ctrl_pkg::ALU_AND);
        add_alu_row(wasm_ctrl_pkg::OP_I32_OR, 2, wasm_ctrl_pkg::ALU_OR);
        add_alu_row(wasm_ctrl_pkg::OP_I32_SHL, 2, wasm_ctrl_pkg::ALU_SHL);
        add_alu_row(wasm_ctrl_pkg::OP_I32_SHR_S, 2, wasm_ctrl_pkg::ALU_SHR_S);
        add_alu_row(wasm_ctrl_pkg::OP_I32_SHR_U, 2, wasm_ctrl_pkg::ALU_SHR_U);
        add_alu_row(wasm_ctrl_pkg::OP_I32_ROTL, 2, wasm_ctrl_pkg::ALU_ROTL);
        add_alu_row(wasm_ctrl_pkg::OP_I32_ROTR, 2, wasm_ctrl_pkg::ALU_ROTR);
    endtask

    task automatic encode_row(input row_t r);
        body.push_back(r.op);
        if (r.kind == wasm_ctrl_pkg::IMM_MEMARG) body.push_back(r.align);
        if (r.kind != wasm_ctrl_pkg::IMM_NONE) begin
            for (int i = 0; i < r.leb_len; i++) body.push_back(leb_byte(r.imm, r.leb_len, i));
        end
    endtask

    // header, a skipped type section, then the code section with two bodies
    task automatic build_program(input logic bad_header, input int unreach_at);
        int   sec_len;
        int   n;
        logic cut;
        prog.delete();
        code.delete();
        exp_q.delete();
        cut = 1'b0;
        for (int i = 0; i < 8; i++) prog.push_back(MAGIC_VERSION[63-8*i -: 8]);
        if (bad_header) prog[3] = prog[3] ^ 8'h20;
        sec_len = 20 + ($urandom % 236); // one or two length bytes
        prog.push_back(8'h01);
        n = leb_size(sec_len);
        for (int i = 0; i < n; i++) prog.push_back(leb_byte(sec_len, n, i));
        for (int i = 0; i < sec_len; i++) prog.push_back(8'($urandom));
        code.push_back(8'd2); // function count
        for (int b = 0; b < 2; b++) begin
            body.delete();
            body.push_back(8'h00); // no local declarations
            if (b == 1) body.push_back(wasm_ctrl_pkg::OP_NOP);
            for (int r = 16*b; r < 16*b + 16; r++) begin
                if (r == unreach_at) begin
                    body.push_back(wasm_ctrl_pkg::OP_UNREACHABLE);
                    cut = 1'b1;
                end
                encode_row(table_q[r]);
                if (!cut && !bad_header) exp_q.push_back(table_q[r]);
            end
            body.push_back(wasm_ctrl_pkg::OP_END);
            n = leb_size(body.size());
            for (int i = 0; i < n; i++) code.push_back(leb_byte(body.size(), n, i));
            foreach (body[i]) code.push_back(body[i]);
        end
        prog.push_back(wasm_ctrl_pkg::SEC_CODE);
        n = leb_size(code.size());
        for (int i = 0; i < n; i++) prog.push_back(leb_byte(code.size(), n, i));
        foreach (code[i]) prog.push_back(code[i]);
    endtask

    task automatic reset_dut();
        @(negedge clk);
        rst_n      = 1'b0;
        window_vld = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic run_program(input string name, input logic exp_done, input logic exp_err);
        int   ptr;
        int   seen;
        row_t r;
        reset_dut();
        ptr        = 0;
        seen       = 0;
        run_limit  = 40*prog.size() + 200;
        run_active = 1'b1;
        while (!(done || error)) begin
            @(negedge clk);
            window_vld = ($urandom % 4) != 0; // idle about one cycle in four
            window     = fetch(ptr);
            @(posedge clk);
            if (op_vld) begin
                assert (window_vld) else begin
                    $display("%s: op_vld came while window_vld was low", name);
                    flow_errors++;
                end
                assert (seen < exp_q.size()) else begin
                    $display("%s: op_vld came with no op left to expect", name);
                    flow_errors++;
                end
                if (seen < exp_q.size()) begin
                    r = exp_q[seen];
                    assert (ctrl == r.exp) else begin
                        $display("CHECK FAILED ctrl (op %0d, opcode %h): got %h expected %h",
                                 seen, r.op, ctrl, r.exp);
                        value_errors++;
                    end
                    if (r.kind != wasm_ctrl_pkg::IMM_NONE) begin
                        assert (imm == r.imm) else begin
                            $display("CHECK FAILED imm (op %0d, opcode %h): got %h expected %h",
                                     seen, r.op, imm, r.imm);
                            value_errors++;
                        end
                    end
                    seen++;
                end
            end
            if (window_vld) ptr += advance;
        end
        repeat (4) begin // parked, nothing may come out
            @(negedge clk);
            window_vld = 1'b1;
            window     = fetch(ptr);
            @(posedge clk);
            assert (!op_vld && advance == '0) else begin
                $display("%s: op or advance seen after the run ended", name);
                flow_errors++;
            end
        end
        @(negedge clk);
        window_vld = 1'b0;
        run_active = 1'b0;
        assert (seen == exp_q.size()) else begin
            $display("%s: %0d ops seen but %0d expected", name, seen, exp_q.size());
            flow_errors++;
        end
        assert (done == exp_done) else begin
            $display("CHECK FAILED done (%s): got %h expected %h", name, done, exp_done);
            value_errors++;
        end
        assert (error == exp_err) else begin
            $display("CHECK FAILED error (%s): got %h expected %h", name, error, exp_err);
            value_errors++;
        end
    endtask

    initial begin
        void'($urandom(75671));
        rst_n        = 1'b0;
        window_vld   = 1'b0;
        window       = '0;
        value_errors = 0;
        flow_errors  = 0;
        run_limit    = 0;
        run_active   = 1'b0;
        fill_table();
        build_program(1'b0, -1);
        run_program("valid module", 1'b1, 1'b0);
        build_program(1'b1, -1);
        run_program("corrupted header", 1'b0, 1'b1);
        build_program(1'b0, 9); // unreachable in front of the store
        run_program("unreachable in body", 1'b0, 1'b1);
        $display("errors: %0d value mismatches, %0d sequence errors", value_errors, flow_errors);
        if (value_errors == 0 && flow_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
logic/wasm_ctrl_pkg.sv
logic/leb128_decoder.sv
logic/opcode_decoder.sv
logic/section_parser.sv
logic/wasm_ctrl_unit.sv
verif/wasm_ctrl_unit_chk.sv
verif/wasm_ctrl_unit_tb.sv

// ==== Bender.yml ====
package:
  name: wasm_ctrl_unit

sources:
  - logic/wasm_ctrl_pkg.sv
  - logic/leb128_decoder.sv
  - logic/opcode_decoder.sv
  - logic/section_parser.sv
  - logic/wasm_ctrl_unit.sv
  - target: test
    files:
      - verif/wasm_ctrl_unit_chk.sv
      - verif/wasm_ctrl_unit_tb.sv
